//--- source/fprint_pkg.sv
package fprint_pkg;

	// Bus and table sizes
	localparam int CSR_AW    = 8;
	localparam int DATA_W    = 32;
	localparam int TASK_W    = 4;
	localparam int NUM_TASKS = 16;
	localparam int FPRINT_W  = 32;

	// Full-address register offsets
	localparam logic [CSR_AW-1:0] EXCEPTION_OFS = 8'h00;
	localparam logic [CSR_AW-1:0] SUCCESS_OFS   = 8'h01;
	localparam logic [CSR_AW-1:0] FAIL_OFS      = 8'h02;
	localparam logic [CSR_AW-1:0] MAXCOUNT_OFS  = 8'h03;

	// Core assignment matched on address bits 5:0 with the row in bits 7:6
	localparam logic [5:0] CORE_ASSIGN_OFS = 6'h08;

	// Pointer directories matched on address bits 7:4 with the task in bits 3:0
	localparam logic [3:0] START_DIR = 4'h1;
	localparam logic [3:0] END_DIR   = 4'h2;

	// Exception register as seen by software
	typedef struct packed {
		logic                     irq;
		logic                     collision;
		logic [DATA_W-TASK_W-3:0] reserved;
		logic [TASK_W-1:0]        task_id;
	} exception_t;

	// One fingerprint submission from a physical core
	typedef struct packed {
		logic                valid;
		logic [3:0]          core_id;
		logic [TASK_W-1:0]   task_id;
		logic [FPRINT_W-1:0] fprint;
	} fprint_t;

	// Result of one checkpoint comparison
	typedef struct packed {
		logic [TASK_W-1:0] task_id;
		logic              collision;
	} comp_status_t;

	// Write data seen as a core assignment entry
	typedef struct packed {
		logic [DATA_W-9:0] reserved;
		logic [3:0]        table_ofs;
		logic [3:0]        core_id;
	} core_assign_t;

	// Bus write word, plain or decoded as an assignment entry
	typedef union packed {
		logic [DATA_W-1:0] raw;
		core_assign_t      core_assign;
	} csr_wdata_u;

endpackage

//--- source/comparator_csr.sv
`timescale 1ns/1ps

module comparator_csr #(
	parameter int RAM_AW = 9
) (
	input  logic                                  clk,
	input  logic                                  reset,

	input  logic [fprint_pkg::CSR_AW-1:0]         csr_address,
	input  logic                                  csr_read,
	input  logic                                  csr_write,
	input  logic [fprint_pkg::DATA_W-1:0]         csr_writedata,
	output logic [fprint_pkg::DATA_W-1:0]         csr_readdata,
	output logic                                  csr_waitrequest,

	input  logic                                  comp_status_write,
	input  fprint_pkg::comp_status_t              comp_status,
	output logic                                  comp_status_ack,

	output logic                                  maxcount_write,
	output logic [fprint_pkg::DATA_W-1:0]         maxcount_data,

	input  logic [fprint_pkg::TASK_W-1:0]         fprint_task,
	input  logic [3:0]                            physical_core_id,
	output logic                                  logical_core_id,
	output logic [RAM_AW-1:0]                     start_pointer_ex,
	output logic [RAM_AW-1:0]                     end_pointer_ex,

	input  logic [fprint_pkg::TASK_W-1:0]         comp_task,
	output logic [RAM_AW-1:0]                     start_pointer_comp,
	output logic [RAM_AW-1:0]                     end_pointer_comp,

	output logic                                  set_head_tail,
	output logic [fprint_pkg::TASK_W-1:0]         head_tail_task,
	output logic [RAM_AW-1:0]                     head_tail_data,
	input  logic                                  head_tail_ack,

	output logic                                  irq
);

	typedef enum logic [2:0] {
		idle,
		st_csr_write,
		st_csr_read,
		st_wait,
		st_head_tail,
		st_comp_write,
		st_comp_ack
	} state_t;

	state_t state;

	fprint_pkg::exception_t                  exception_q;
	logic [fprint_pkg::NUM_TASKS-1:0]        success_q;
	logic [fprint_pkg::NUM_TASKS-1:0]        fail_q;

	logic [RAM_AW-1:0] start_ptr_mem [fprint_pkg::NUM_TASKS];
	logic [RAM_AW-1:0] end_ptr_mem   [fprint_pkg::NUM_TASKS];
	logic [3:0]        core_assign_tbl [fprint_pkg::NUM_TASKS];

	fprint_pkg::csr_wdata_u wdata_u;

	logic exception_sel;
	logic success_sel;
	logic fail_sel;
	logic maxcount_sel;
	logic start_sel;
	logic end_sel;
	logic core_assign_sel;
	logic reg_write;
	logic [fprint_pkg::TASK_W-1:0] dir_task;

	// Address decode
	assign exception_sel   = (csr_address == fprint_pkg::EXCEPTION_OFS);
	assign success_sel     = (csr_address == fprint_pkg::SUCCESS_OFS);
	assign fail_sel        = (csr_address == fprint_pkg::FAIL_OFS);
	assign maxcount_sel    = (csr_address == fprint_pkg::MAXCOUNT_OFS);
	assign start_sel       = (csr_address[7:4] == fprint_pkg::START_DIR);
	assign end_sel         = (csr_address[7:4] == fprint_pkg::END_DIR);
	assign core_assign_sel = (csr_address[5:0] == fprint_pkg::CORE_ASSIGN_OFS);
	assign dir_task        = csr_address[fprint_pkg::TASK_W-1:0];

	assign wdata_u.raw = csr_writedata;
	assign reg_write   = (state == st_csr_write);

	// Bus first, then comparator reports while no interrupt is pending
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= idle;
		end else begin
			case (state)
				idle: begin
					if (csr_write)
						state <= st_csr_write;
					else if (csr_read)
						state <= st_csr_read;
					else if (comp_status_write && !irq)
						state <= st_comp_write;
				end
				st_csr_write: state <= start_sel ? st_head_tail : st_wait;
				st_csr_read:  state <= st_wait;
				st_head_tail: begin
					if (head_tail_ack)
						state <= st_wait;
				end
				st_comp_write: state <= st_comp_ack;
				default:       state <= idle;
			endcase
		end
	end

	assign csr_waitrequest = (state != st_wait);
	assign comp_status_ack = (state == st_comp_ack);
	assign set_head_tail   = (state == st_head_tail);
	assign head_tail_task  = dir_task;
	assign head_tail_data  = csr_writedata[RAM_AW-1:0];
	assign maxcount_write  = reg_write && maxcount_sel;
	assign maxcount_data   = csr_writedata;
	assign irq             = exception_q.irq;

	always_comb begin
		if (exception_sel)
			csr_readdata = exception_q;
		else if (success_sel)
			csr_readdata = {{(fprint_pkg::DATA_W-fprint_pkg::NUM_TASKS){1'b0}}, success_q};
		else if (fail_sel)
			csr_readdata = {{(fprint_pkg::DATA_W-fprint_pkg::NUM_TASKS){1'b0}}, fail_q};
		else
			csr_readdata = '0;
	end

	// Status registers
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			exception_q <= '0;
			success_q   <= '0;
			fail_q      <= '0;
		end else if (reg_write && exception_sel) begin
			// Software write replaces the word, which also drops irq
			exception_q <= fprint_pkg::exception_t'(csr_writedata);
			success_q   <= '0;
			fail_q      <= '0;
		end else if (state == st_comp_write) begin
			exception_q.irq       <= 1'b1;
			exception_q.collision <= comp_status.collision;
			exception_q.task_id   <= comp_status.task_id;
			success_q[comp_status.task_id] <= !comp_status.collision;
			fail_q[comp_status.task_id]    <= comp_status.collision;
		end
	end

	// Pointer tables with one port for the store side and one for the comparator
	always_ff @(posedge clk) begin
		if (reg_write && start_sel)
			start_ptr_mem[dir_task] <= csr_writedata[RAM_AW-1:0];
		if (reg_write && end_sel)
			end_ptr_mem[dir_task] <= csr_writedata[RAM_AW-1:0];
		start_pointer_ex   <= start_ptr_mem[fprint_task];
		end_pointer_ex     <= end_ptr_mem[fprint_task];
		start_pointer_comp <= start_ptr_mem[comp_task];
		end_pointer_comp   <= end_ptr_mem[comp_task];
	end

	// The lookup reads only row 1 of the assignment table
	always_ff @(posedge clk) begin
		if (reg_write && core_assign_sel && (csr_address[7:6] == 2'b01))
			core_assign_tbl[wdata_u.core_assign.table_ofs] <=
				wdata_u.core_assign.core_id;
	end

	// Logical 1 is whichever physical core row 1 names for this task
	assign logical_core_id = (core_assign_tbl[fprint_task] == physical_core_id);

endmodule

//--- source/fprint_store.sv
`timescale 1ns/1ps

module fprint_store #(
	parameter int RAM_AW = 9
) (
	input  logic                              clk,
	input  logic                              reset,
	input  fprint_pkg::fprint_t               core_fprint,

	output logic [fprint_pkg::TASK_W-1:0]     fprint_task,
	output logic [3:0]                        physical_core_id,
	input  logic                              logical_core_id,
	input  logic [RAM_AW-1:0]                 start_pointer_ex,
	input  logic [RAM_AW-1:0]                 end_pointer_ex,

	input  logic                              set_head_tail,
	input  logic [fprint_pkg::TASK_W-1:0]     head_tail_task,
	input  logic [RAM_AW-1:0]                 head_tail_data,
	output logic                              head_tail_ack,

	input  logic [RAM_AW-1:0]                 start_pointer_comp,
	input  logic [RAM_AW-1:0]                 end_pointer_comp,
	input  logic [fprint_pkg::TASK_W-1:0]     pop_task,
	input  logic                              pop,

	output logic [fprint_pkg::FPRINT_W-1:0]   head_fprint_0,
	output logic [fprint_pkg::FPRINT_W-1:0]   head_fprint_1,
	output logic [RAM_AW:0]                   count_0,
	output logic [RAM_AW:0]                   count_1
);

	logic [RAM_AW-1:0] tail_q  [fprint_pkg::NUM_TASKS][2];
	logic [RAM_AW-1:0] head_q  [fprint_pkg::NUM_TASKS][2];
	logic [RAM_AW:0]   count_q [fprint_pkg::NUM_TASKS][2];

	// Submission held one cycle while the pointers are looked up
	logic                            sub_valid_q;
	logic                            sub_lc_q;
	logic [fprint_pkg::TASK_W-1:0]   sub_task_q;
	logic [fprint_pkg::FPRINT_W-1:0] sub_fprint_q;

	function automatic logic [RAM_AW-1:0] next_ptr(
		input logic [RAM_AW-1:0] ptr,
		input logic [RAM_AW-1:0] first,
		input logic [RAM_AW-1:0] last
	);
		return (ptr == last) ? first : ptr + 1'b1;
	endfunction

	assign fprint_task      = core_fprint.task_id;
	assign physical_core_id = core_fprint.core_id;

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			sub_valid_q <= 1'b0;
		else
			sub_valid_q <= core_fprint.valid;
	end

	always_ff @(posedge clk) begin
		sub_lc_q     <= logical_core_id;
		sub_task_q   <= core_fprint.task_id;
		sub_fprint_q <= core_fprint.fprint;
	end

	// Ack one cycle after the request is seen
	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			head_tail_ack <= 1'b0;
		else
			head_tail_ack <= set_head_tail && !head_tail_ack;
	end

	// Per task and logical core region state
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int t = 0; t < fprint_pkg::NUM_TASKS; t++) begin
				for (int c = 0; c < 2; c++) begin
					tail_q[t][c]  <= '0;
					head_q[t][c]  <= '0;
					count_q[t][c] <= '0;
				end
			end
		end else begin
			for (int t = 0; t < fprint_pkg::NUM_TASKS; t++) begin
				for (int c = 0; c < 2; c++) begin
					logic inc;
					logic dec;
					inc = sub_valid_q && (sub_task_q == t) && (sub_lc_q == c[0]);
					dec = pop && (pop_task == t);
					if (set_head_tail && (head_tail_task == t)) begin
						tail_q[t][c]  <= head_tail_data;
						head_q[t][c]  <= head_tail_data;
						count_q[t][c] <= '0;
					end else begin
						if (inc)
							tail_q[t][c] <= next_ptr(tail_q[t][c], start_pointer_ex,
								end_pointer_ex);
						if (dec)
							head_q[t][c] <= next_ptr(head_q[t][c], start_pointer_comp,
								end_pointer_comp);
						if (inc && !dec)
							count_q[t][c] <= count_q[t][c] + 1'b1;
						else if (dec && !inc)
							count_q[t][c] <= count_q[t][c] - 1'b1;
					end
				end
			end
		end
	end

	// One RAM per logical core with a registered head read
	for (genvar c = 0; c < 2; c++) begin : g_core
		logic [fprint_pkg::FPRINT_W-1:0] ram [2**RAM_AW];
		logic [fprint_pkg::FPRINT_W-1:0] rd_q;

		always_ff @(posedge clk) begin
			if (sub_valid_q && (sub_lc_q == 1'(c)))
				ram[tail_q[sub_task_q][c]] <= sub_fprint_q;
			rd_q <= ram[head_q[pop_task][c]];
		end
	end

	assign head_fprint_0 = g_core[0].rd_q;
	assign head_fprint_1 = g_core[1].rd_q;
	assign count_0       = count_q[pop_task][0];
	assign count_1       = count_q[pop_task][1];

endmodule

//--- source/fprint_comparator.sv
`timescale 1ns/1ps

module fprint_comparator #(
	parameter int RAM_AW = 9
) (
	input  logic                              clk,
	input  logic                              reset,

	input  logic                              maxcount_write,
	input  logic [fprint_pkg::DATA_W-1:0]     maxcount_data,

	output logic [fprint_pkg::TASK_W-1:0]     pop_task,
	output logic                              pop,

	input  logic [fprint_pkg::FPRINT_W-1:0]   head_fprint_0,
	input  logic [fprint_pkg::FPRINT_W-1:0]   head_fprint_1,
	input  logic [RAM_AW:0]                   count_0,
	input  logic [RAM_AW:0]                   count_1,

	output logic                              comp_status_write,
	output fprint_pkg::comp_status_t          comp_status,
	input  logic                              comp_status_ack
);

	typedef enum logic [1:0] {
		st_scan,
		st_compare,
		st_gap,
		st_report
	} state_t;

	state_t state;

	logic [RAM_AW:0]               maxcount_q;
	logic [RAM_AW:0]               remaining_q;
	logic [fprint_pkg::TASK_W-1:0] task_q;
	logic                          collision_q;
	logic                          ready;
	logic                          mismatch;

	// Both logical cores hold a full checkpoint
	assign ready = (maxcount_q != '0) && (count_0 >= maxcount_q) && (count_1 >= maxcount_q);
	assign mismatch = (head_fprint_0 != head_fprint_1);

	assign pop_task          = task_q;
	assign pop               = (state == st_compare);
	assign comp_status_write = (state == st_report);
	assign comp_status.task_id   = task_q;
	assign comp_status.collision = collision_q;

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			maxcount_q <= '0;
		else if (maxcount_write)
			maxcount_q <= maxcount_data[RAM_AW:0];
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state       <= st_scan;
			task_q      <= '0;
			remaining_q <= '0;
			collision_q <= 1'b0;
		end else begin
			case (state)
				st_scan: begin
					if (ready) begin
						state       <= st_compare;
						remaining_q <= maxcount_q;
						collision_q <= 1'b0;
					end else begin
						task_q <= task_q + 1'b1;
					end
				end
				st_compare: begin
					collision_q <= collision_q | mismatch;
					remaining_q <= remaining_q - 1'b1;
					if (remaining_q == 1)
						state <= st_report;
					else
						state <= st_gap;
				end
				// Lets the head read catch up with the popped pointer
				st_gap: state <= st_compare;
				st_report: begin
					if (comp_status_ack) begin
						state  <= st_scan;
						task_q <= task_q + 1'b1;
					end
				end
				default: state <= st_scan;
			endcase
		end
	end

endmodule

//--- source/fprint_unit_top.sv
`timescale 1ns/1ps

module fprint_unit_top #(
	parameter int RAM_AW = 9
) (
	input  logic                              clk,
	input  logic                              reset,
	input  logic [fprint_pkg::CSR_AW-1:0]     csr_address,
	input  logic                              csr_read,
	input  logic                              csr_write,
	input  logic [fprint_pkg::DATA_W-1:0]     csr_writedata,
	output logic [fprint_pkg::DATA_W-1:0]     csr_readdata,
	output logic                              csr_waitrequest,
	input  fprint_pkg::fprint_t               core_fprint,
	output logic                              irq
);

	// Lookup between store and register block
	logic [fprint_pkg::TASK_W-1:0]   fprint_task;
	logic [3:0]                      physical_core_id;
	logic                            logical_core_id;
	logic [RAM_AW-1:0]               start_pointer_ex;
	logic [RAM_AW-1:0]               end_pointer_ex;

	logic                            set_head_tail;
	logic [fprint_pkg::TASK_W-1:0]   head_tail_task;
	logic [RAM_AW-1:0]               head_tail_data;
	logic                            head_tail_ack;

	// Comparator side
	logic [fprint_pkg::TASK_W-1:0]   pop_task;
	logic                            pop;
	logic [RAM_AW-1:0]               start_pointer_comp;
	logic [RAM_AW-1:0]               end_pointer_comp;
	logic [fprint_pkg::FPRINT_W-1:0] head_fprint_0;
	logic [fprint_pkg::FPRINT_W-1:0] head_fprint_1;
	logic [RAM_AW:0]                 count_0;
	logic [RAM_AW:0]                 count_1;
	logic                            maxcount_write;
	logic [fprint_pkg::DATA_W-1:0]   maxcount_data;
	logic                            comp_status_write;
	fprint_pkg::comp_status_t        comp_status;
	logic                            comp_status_ack;

	comparator_csr #(.RAM_AW(RAM_AW)) u_csr (
		.clk, .reset,
		.csr_address, .csr_read, .csr_write, .csr_writedata,
		.csr_readdata, .csr_waitrequest,
		.comp_status_write, .comp_status, .comp_status_ack,
		.maxcount_write, .maxcount_data,
		.fprint_task, .physical_core_id, .logical_core_id,
		.start_pointer_ex, .end_pointer_ex,
		.comp_task(pop_task), .start_pointer_comp, .end_pointer_comp,
		.set_head_tail, .head_tail_task, .head_tail_data, .head_tail_ack,
		.irq
	);

	fprint_store #(.RAM_AW(RAM_AW)) u_store (
		.clk, .reset, .core_fprint,
		.fprint_task, .physical_core_id, .logical_core_id,
		.start_pointer_ex, .end_pointer_ex,
		.set_head_tail, .head_tail_task, .head_tail_data, .head_tail_ack,
		.start_pointer_comp, .end_pointer_comp, .pop_task, .pop,
		.head_fprint_0, .head_fprint_1, .count_0, .count_1
	);

	fprint_comparator #(.RAM_AW(RAM_AW)) u_comparator (
		.clk, .reset,
		.maxcount_write, .maxcount_data,
		.pop_task, .pop,
		.head_fprint_0, .head_fprint_1, .count_0, .count_1,
		.comp_status_write, .comp_status, .comp_status_ack
	);

endmodule

//--- sim/fprint_unit_tb.sv
`timescale 1ns/1ps

module fprint_unit_tb;

	localparam int RAM_AW   = 9;
	localparam int NUM_ROWS = 6;

	// One test row
	typedef struct packed {
		logic [3:0]        task_id;
		logic [3:0]        phys_a;
		logic [3:0]        phys_b;
		logic [3:0]        row1;
		logic [RAM_AW-1:0] start_ptr;
		logic [RAM_AW-1:0] end_ptr;
		logic [RAM_AW:0]   maxcount;
		logic [1:0]        checkpoints;
		logic              inject;
		logic [3:0]        bad_index;
		logic              second;
	} row_t;

	logic                clk;
	logic                reset;
	logic [7:0]          csr_address;
	logic                csr_read;
	logic                csr_write;
	logic [31:0]         csr_writedata;
	logic [31:0]         csr_readdata;
	logic                csr_waitrequest;
	fprint_pkg::fprint_t core_fprint;
	logic                irq;

	row_t rows [NUM_ROWS];
	int   errors;

	fprint_unit_top #(.RAM_AW(RAM_AW)) dut (
		.clk, .reset,
		.csr_address, .csr_read, .csr_write, .csr_writedata,
		.csr_readdata, .csr_waitrequest,
		.core_fprint, .irq
	);

	always #10 clk = ~clk;

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			$display("[ERROR] %s = 0x%08h, expected 0x%08h", name, got, exp);
			errors++;
		end
	endtask

	task automatic bus_write(input logic [7:0] addr, input logic [31:0] data);
		@(negedge clk);
		csr_address   = addr;
		csr_writedata = data;
		csr_write     = 1'b1;
		do
			@(negedge clk);
		while (csr_waitrequest);
		csr_write = 1'b0;
	endtask

	task automatic bus_read(input logic [7:0] addr, output logic [31:0] data);
		@(negedge clk);
		csr_address = addr;
		csr_read    = 1'b1;
		do
			@(negedge clk);
		while (csr_waitrequest);
		data     = csr_readdata;
		csr_read = 1'b0;
	endtask

	task automatic submit_fprint(input logic [3:0] core, input logic [3:0] task_id,
		input logic [31:0] value);
		@(negedge clk);
		core_fprint.valid   = 1'b1;
		core_fprint.core_id = core;
		core_fprint.task_id = task_id;
		core_fprint.fprint  = value;
		@(negedge clk);
		core_fprint.valid = 1'b0;
	endtask

	// Row 1 of the assignment table names logical core 1
	task automatic configure_task(input logic [3:0] task_id, input logic [3:0] row1,
		input logic [RAM_AW-1:0] first, input logic [RAM_AW-1:0] last);
		bus_write({2'b01, fprint_pkg::CORE_ASSIGN_OFS}, {24'h0, task_id, row1});
		bus_write({fprint_pkg::END_DIR, task_id}, 32'(last));
		bus_write({fprint_pkg::START_DIR, task_id}, 32'(first));
	endtask

	task automatic wait_irq();
		while (!irq)
			@(negedge clk);
	endtask

	// Expected registers for one report after a clear
	task automatic check_result(input logic [3:0] task_id, input logic collide);
		logic [31:0] data;
		logic [31:0] mask;
		mask = 32'h1 << task_id;
		bus_read(fprint_pkg::EXCEPTION_OFS, data);
		check_value("exception", data, {1'b1, collide, 26'h0, task_id});
		bus_read(fprint_pkg::SUCCESS_OFS, data);
		check_value("success", data, collide ? 32'h0 : mask);
		bus_read(fprint_pkg::FAIL_OFS, data);
		check_value("fail", data, collide ? mask : 32'h0);
	endtask

	task automatic check_cleared();
		logic [31:0] data;
		check_value("irq", {31'h0, irq}, 32'h0);
		bus_read(fprint_pkg::EXCEPTION_OFS, data);
		check_value("exception", data, 32'h0);
		bus_read(fprint_pkg::SUCCESS_OFS, data);
		check_value("success", data, 32'h0);
		bus_read(fprint_pkg::FAIL_OFS, data);
		check_value("fail", data, 32'h0);
	endtask

	// Watchdog
	initial begin
		repeat (NUM_ROWS * 600) @(posedge clk);
		$display("Watchdog expired before the tests finished");
		$display("Some tests failed");
		$finish;
	end

	initial begin
		row_t        row;
		logic [31:0] fp;
		logic [3:0]  second_task;
		logic        bad;
		logic        collide;
		int          pair_index;
		int          errors_before;
		int          failed_tests;

		clk           = 1'b0;
		reset         = 1'b1;
		csr_address   = '0;
		csr_read      = 1'b0;
		csr_write     = 1'b0;
		csr_writedata = '0;
		core_fprint   = '0;
		errors        = 0;
		failed_tests  = 0;
		void'($urandom(32'h21bc_89ee));

		// task, phys a, phys b, row1, start, end, maxcount, chk, inject, index, second
		rows[0] = '{4'd3, 4'd1, 4'd2, 4'd2, 9'h000, 9'h0ff, 10'd8, 2'd1, 1'b0, 4'd0, 1'b0};
		rows[1] = '{4'd5, 4'd1, 4'd2, 4'd2, 9'h020, 9'h03f, 10'd6, 2'd1, 1'b1, 4'd4, 1'b0};
		rows[2] = '{4'd9, 4'd7, 4'd12, 4'd7, 9'h040, 9'h07f, 10'd5, 2'd1, 1'b0, 4'd0, 1'b0};
		rows[3] = '{4'd10, 4'd7, 4'd12, 4'd7, 9'h080, 9'h08f, 10'd4, 2'd1, 1'b1, 4'd0, 1'b0};
		// Five entries and three per checkpoint force both pointers to wrap
		rows[4] = '{4'd14, 4'd4, 4'd11, 4'd11, 9'h0a0, 9'h0a4, 10'd3, 2'd3, 1'b1, 4'd4, 1'b0};
		rows[5] = '{4'd0, 4'd2, 4'd6, 4'd6, 9'h0c0, 9'h0cf, 10'd4, 2'd1, 1'b0, 4'd0, 1'b1};

		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		check_value("csr_waitrequest", {31'h0, csr_waitrequest}, 32'h1);
		check_cleared();
		$display("Test 0 (reset values): %s", errors == 0 ? "ok" : "FAILED");
		if (errors != 0)
			failed_tests++;

		for (int r = 0; r < NUM_ROWS; r++) begin
			row           = rows[r];
			errors_before = errors;
			pair_index    = 0;
			configure_task(row.task_id, row.row1, row.start_ptr, row.end_ptr);
			bus_write(fprint_pkg::MAXCOUNT_OFS, 32'(row.maxcount));

			for (int c = 0; c < row.checkpoints; c++) begin
				collide = 1'b0;
				for (int i = 0; i < row.maxcount; i++) begin
					fp  = $urandom();
					bad = row.inject && (pair_index == row.bad_index);
					collide |= bad;
					submit_fprint(row.phys_a, row.task_id, fp);
					submit_fprint(row.phys_b, row.task_id, bad ? ~fp : fp);
					pair_index++;
				end
				wait_irq();
				check_result(row.task_id, collide);

				if (row.second) begin
					// Second task in the upper half of the RAM
					second_task = row.task_id ^ 4'h8;
					configure_task(second_task, row.row1, row.start_ptr + 9'h100,
						row.end_ptr + 9'h100);
					for (int i = 0; i < row.maxcount; i++) begin
						fp = $urandom();
						submit_fprint(row.phys_a, second_task, fp);
						submit_fprint(row.phys_b, second_task, fp);
					end
					while (!dut.u_comparator.comp_status_write)
						@(negedge clk);
					// Report is held and the first result is still visible
					check_result(row.task_id, collide);
					bus_write(fprint_pkg::EXCEPTION_OFS, 32'h0);
					wait_irq();
					check_result(second_task, 1'b0);
				end

				bus_write(fprint_pkg::EXCEPTION_OFS, 32'h0);
			end

			check_cleared();
			$display("Test %0d (task %0d): %s", r + 1, row.task_id,
				errors == errors_before ? "ok" : "FAILED");
			if (errors != errors_before)
				failed_tests++;
		end

		$display("Tests run: %0d, tests failed: %0d, checks failed: %0d",
			NUM_ROWS + 1, failed_tests, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

//--- src.f
source/fprint_pkg.sv
source/comparator_csr.sv
source/fprint_store.sv
source/fprint_comparator.sv
source/fprint_unit_top.sv
sim/fprint_unit_tb.sv

//--- Bender.yml
package:
  name: fprint_unit

sources:
  - files:
      - source/fprint_pkg.sv
      - source/comparator_csr.sv
      - source/fprint_store.sv
      - source/fprint_comparator.sv
      - source/fprint_unit_top.sv
  - target: simulation
    files:
      - sim/fprint_unit_tb.sv
